//--- src.f
verilog/mycpuPkg.sv
verilog/busIf.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/hazard.sv
verilog/MyCore.sv
test/coreAssert_assert.sv
test/tbCore.sv

//--- test/tbCore.sv
`timescale 1ns/100ps

module tbCore import mycpuPkg::*; ();
    localparam int bodyLen = 300;
    localparam int maxLatency = 5;   // Request cycle, up to 3 waits, ready cycle
    localparam logic [31:0] jAddr = resetPc + 32'd4 * (bodyLen + 31);

    logic        clk;
    logic        resetn;
    logic        iValid, iReady, dValid, dWrite, dReady;
    logic [31:0] iAddr, iData, dAddr, dWdata, dRdata;
    logic [31:0] lfsr;
    logic [31:0] prog [0:511];
    logic [31:0] dmem [0:511];
    logic [31:0] trace [0:511];   // Model PC sequence
    logic [31:0] opAddr [0:511];  // Model data requests in order
    logic [31:0] opData [0:511];
    logic        opWr [0:511];
    int          traceLen, opCount, instrCount, fetchIdx, opIdx, cycles, limit, iWait, dWait;

    MyCore MyCore_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = 32'd0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic buildProgram();
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        logic [3:0]  sel;
        logic        prevBeq;
        prevBeq = 1'b0;
        for (int k = 0; k < 512; k++) begin
            prog[k] = 32'd0;
            dmem[k] = randBits(32);
        end
        for (int r = 1; r < 32; r++) begin
            imm = randBits(16);
            prog[r - 1] = {opAddiu, 5'd0, r[4:0], imm};
        end
        for (int k = 31; k < bodyLen; k++) begin
            rs = randBits(3);  // Small register pool for more hazards
            rt = randBits(3);
            rd = randBits(3);
            imm = randBits(16);
            sel = randBits(4);
            if (sel >= 4'd14 && prevBeq)
                sel = 4'd0;  // No branch in a delay slot
            prevBeq = sel >= 4'd14;
            case (sel)
                4'd0:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnAddu};
                4'd1:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnSubu};
                4'd2:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnAnd};
                4'd3:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnOr};
                4'd4:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnXor};
                4'd5:  prog[k] = {opSpecial, rs, rt, rd, 5'd0, fnSlt};
                4'd6:  prog[k] = {opSpecial, 5'd0, rt, rd, imm[4:0], fnSll};
                4'd7:  prog[k] = {opAddiu, rs, rt, imm};
                4'd8:  prog[k] = {opOri, rs, rt, imm};
                4'd9:  prog[k] = {opLui, 5'd0, rt, imm};
                4'd10, 4'd11: prog[k] = {opLw, 5'd0, rt, 6'd0, imm[9:2], 2'b00};
                4'd12, 4'd13: prog[k] = {opSw, 5'd0, rt, 6'd0, imm[9:2], 2'b00};
                default: prog[k] = {opBeq, rs, imm[15] ? rs : rt, {14'd0, imm[1:0]} + 16'd1};
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            imm = 16'h0400 + r * 4;  // Register dump area
            prog[bodyLen + r - 1] = {opSw, 5'd0, r[4:0], imm};
        end
        prog[bodyLen + 31] = {opJ, jAddr[27:2]};
    endtask

    task automatic runModel();
        logic [31:0] regs [0:31];
        logic [31:0] refMem [0:511];
        logic [31:0] pc, npc, nn, ins, a, b, imm, addr;
        int          endStep;
        for (int k = 0; k < 512; k++)
            refMem[k] = dmem[k];
        for (int k = 0; k < 32; k++)
            regs[k] = 32'd0;
        pc = resetPc;
        npc = resetPc + 32'd4;
        endStep = -1;
        traceLen = 0;
        opCount = 0;
        // Fetch runs ahead of the stores so a few turns of the final loop are traced too
        while (endStep < 0 || traceLen < endStep + 20) begin
            ins = prog[(pc - resetPc) >> 2];
            if (pc == jAddr && endStep < 0)
                endStep = traceLen;
            trace[traceLen] = pc;
            traceLen++;
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nn = npc + 32'd4;
            case (ins[31:26])
                opSpecial: case (ins[5:0])
                    fnAddu: regs[ins[15:11]] = a + b;
                    fnSubu: regs[ins[15:11]] = a - b;
                    fnAnd:  regs[ins[15:11]] = a & b;
                    fnOr:   regs[ins[15:11]] = a | b;
                    fnXor:  regs[ins[15:11]] = a ^ b;
                    fnSlt:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSll:  regs[ins[15:11]] = b << ins[10:6];
                    default: ;
                endcase
                opAddiu: regs[ins[20:16]] = a + imm;
                opOri:   regs[ins[20:16]] = a | {16'd0, ins[15:0]};
                opLui:   regs[ins[20:16]] = {ins[15:0], 16'd0};
                opLw: begin
                    regs[ins[20:16]] = refMem[addr[10:2]];
                    opAddr[opCount] = addr;
                    opWr[opCount] = 1'b0;
                    opData[opCount] = refMem[addr[10:2]];
                    opCount++;
                end
                opSw: begin
                    refMem[addr[10:2]] = b;
                    opAddr[opCount] = addr;
                    opWr[opCount] = 1'b1;
                    opData[opCount] = b;
                    opCount++;
                end
                opBeq: if (a == b) nn = pc + 32'd4 + (imm << 2);
                opJ:   nn = {pc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = 32'd0;
            pc = npc;
            npc = nn;
        end
        instrCount = endStep;
    endtask

    // Instruction and data memory models
    always @(posedge clk) begin
        if (resetn) begin
            iReady <= 1'b0;
            dReady <= 1'b0;
            iWait = 0;
            dWait = 0;
        end else begin
            if (iValid && iReady) begin
                if (fetchIdx < traceLen)
                    checkValue(iAddr, trace[fetchIdx], "fetch address");
                fetchIdx++;
                iReady <= 1'b0;
                iWait = randBits(2);
            end else if (iValid) begin
                if (iWait == 0) begin
                    iReady <= 1'b1;
                    iData  <= prog[iAddr[10:2]];
                end else
                    iWait--;
            end
            if (dValid && dReady) begin
                if (!(iValid && !iReady)) begin  // Taken only when fetch is not waiting too
                    checkValue(opIdx < opCount, 1'b1, "data request beyond the program");
                    checkValue(dAddr, opAddr[opIdx], "data address");
                    checkValue(dWrite, opWr[opIdx], "data direction");
                    if (dWrite) begin
                        checkValue(dWdata, opData[opIdx], "store data");
                        dmem[dAddr[10:2]] = dWdata;
                    end
                    opIdx++;
                    dReady <= 1'b0;
                    dWait = randBits(2);
                end
            end else if (dValid) begin
                if (dWait == 0) begin
                    dReady <= 1'b1;
                    dRdata <= dmem[dAddr[10:2]];
                end else
                    dWait--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: core hung after %0d cycles, %0d of %0d data requests seen",
                     cycles, opIdx, opCount);
            abortRun();
        end
    end

    initial begin
        resetn = 1'b1;
        iReady = 1'b0;
        iData  = 32'd0;
        dReady = 1'b0;
        dRdata = 32'd0;
        lfsr = 32'h4a23_c1bc;
        fetchIdx = 0;
        opIdx = 0;
        cycles = 0;
        limit = 0;
        buildProgram();
        runModel();
        limit = 4 * instrCount * maxLatency + 200;
        repeat (10) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);
        checkValue(iValid, 1'b1, "fetch request in the first cycle after reset");
        checkValue(iAddr, resetPc, "first fetch address");
        wait (opIdx == opCount);
        repeat (20) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- test/coreAssert_assert.sv
`timescale 1ns/100ps

module coreAssert (
    input logic        clk,
    input logic        resetn,
    input logic        iValid,
    input logic [31:0] iAddr,
    input logic        iReady,
    input logic        dValid,
    input logic [31:0] dAddr,
    input logic        dWrite,
    input logic [31:0] dWdata,
    input logic        dReady
);

    // Skip the first reset cycle, before the bus state is cleared
    resetIdle: assert property (@(posedge clk) resetn && $past(resetn) |-> !iValid && !dValid)
        else $error("Bus request raised during reset");

    iHold: assert property (@(posedge clk) disable iff (resetn)
        iValid && !iReady |=> iValid && $stable(iAddr))
        else $error("Instruction request changed before ready");

    dHold: assert property (@(posedge clk) disable iff (resetn)
        dValid && !dReady |=> dValid && $stable(dAddr) && $stable(dWrite) && $stable(dWdata))
        else $error("Data request changed before ready");

    writeQual: assert property (@(posedge clk) disable iff (resetn) dWrite |-> dValid)
        else $error("Data write without a valid request");

endmodule

bind MyCore coreAssert busChecks (.*);

//--- verilog/MyCore.sv
`timescale 1ns/100ps

module MyCore import mycpuPkg::*; (
    input  logic        clk,
    input  logic        resetn,
    output logic        iValid,
    output logic [31:0] iAddr,
    input  logic [31:0] iData,
    input  logic        iReady,
    output logic        dValid,
    output logic [31:0] dAddr,
    output logic        dWrite,
    output logic [31:0] dWdata,
    input  logic [31:0] dRdata,
    input  logic        dReady
);
    instrBusIf ibus();
    dataBusIf  dbus();

    logic        freeze;
    logic        stall;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] pcF, instrF;
    logic [31:0] pcD, instrD;
    logic [4:0]  rsD, rtD;
    logic [31:0] rd1D, rd2D;
    logic [31:0] vsD, vtD, vsE, vtE;
    stageRegT    bundleD, bundleE;
    logic [31:0] aluOutE, storeDataE;
    ctrlT        ctrlM;
    logic [4:0]  destM;
    logic [31:0] aluOutM, storeDataM, resultM;
    logic        regWriteW;
    logic [4:0]  destW;
    logic [31:0] resultW;

    assign iValid     = ibus.valid;
    assign iAddr      = ibus.addr;
    assign ibus.data  = iData;
    assign ibus.ready = iReady;

    assign dValid     = dbus.valid;
    assign dAddr      = dbus.addr;
    assign dWrite     = dbus.write;
    assign dWdata     = dbus.wdata;
    assign dbus.rdata = dRdata;
    assign dbus.ready = dReady;

    // Any bus wait holds the whole pipe
    assign freeze = (iValid && !iReady) || (dValid && !dReady);

    fetch Fetch (
        .clk(clk), .resetn(resetn),
        .freeze(freeze), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .ibus(ibus),
        .pcF(pcF), .instrF(instrF)
    );

    regfile Regfile (
        .clk(clk),
        .ra1(rsD), .ra2(rtD), .wa(destW),
        .we(regWriteW && !freeze),
        .wd(resultW),
        .rd1(rd1D), .rd2(rd2D)
    );

    decode Decode (
        .instr(instrD), .pc(pcD),
        .vs(vsD), .vt(vtD),
        .rs(rsD), .rt(rtD),
        .bundle(bundleD),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    execute Execute (
        .bundle(bundleE),
        .vs(vsE), .vt(vtE),
        .aluOut(aluOutE), .storeData(storeDataE)
    );

    memory Memory (
        .ctrl(ctrlM),
        .aluOut(aluOutM), .storeData(storeDataM),
        .dbus(dbus),
        .result(resultM)
    );

    hazard Hazard (
        .rsD(rsD), .rtD(rtD), .opD(instrD[31:26]),
        .exBundle(bundleE),
        .memCtrl(ctrlM), .memDest(destM), .memAlu(resultM),
        .wbWe(regWriteW), .wbDest(destW), .wbData(resultW),
        .rd1D(rd1D), .rd2D(rd2D),
        .vsD(vsD), .vtD(vtD), .vsE(vsE), .vtE(vtE),
        .stall(stall)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            instrD    <= 32'd0;
            bundleE   <= '0;
            ctrlM     <= '0;
            regWriteW <= 1'b0;
        end else if (!freeze) begin
            if (!stall)
                instrD <= instrF;
            bundleE   <= stall ? '0 : bundleD;  // Bubble on load-use
            ctrlM     <= bundleE.ctrl;
            regWriteW <= ctrlM.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!stall)
                pcD <= pcF;
            destM      <= bundleE.dest;
            aluOutM    <= aluOutE;
            storeDataM <= storeDataE;
            destW      <= destM;
            resultW    <= resultM;
        end
    end

endmodule

//--- verilog/hazard.sv
`timescale 1ns/100ps

module hazard import mycpuPkg::*; (
    input  logic [4:0]  rsD,
    input  logic [4:0]  rtD,
    input  logic [5:0]  opD,
    input  stageRegT    exBundle,
    input  ctrlT        memCtrl,
    input  logic [4:0]  memDest,
    input  logic [31:0] memAlu,  // Memory stage result, load data included
    input  logic        wbWe,
    input  logic [4:0]  wbDest,
    input  logic [31:0] wbData,
    input  logic [31:0] rd1D,
    input  logic [31:0] rd2D,
    output logic [31:0] vsD,
    output logic [31:0] vtD,
    output logic [31:0] vsE,
    output logic [31:0] vtE,
    output logic        stall
);
    logic exHit;

    // Newest producer wins
    function automatic logic [31:0] pick(input logic [4:0] r, input logic [31:0] raw);
        if (r != 5'd0 && memCtrl.regWrite && memDest == r)
            return memAlu;
        if (r != 5'd0 && wbWe && wbDest == r)
            return wbData;
        return raw;
    endfunction

    always_comb begin
        vsD = pick(rsD, rd1D);
        vtD = pick(rtD, rd2D);
        vsE = pick(exBundle.rs, exBundle.vs);
        vtE = pick(exBundle.rt, exBundle.vt);
    end

    assign exHit = exBundle.ctrl.regWrite && exBundle.dest != 5'd0
                   && (exBundle.dest == rsD || exBundle.dest == rtD);

    // Load result not ready yet, or beq compare in decode needs an ALU result
    assign stall = exHit && (exBundle.ctrl.memRead || opD == opBeq);

endmodule

//--- verilog/memory.sv
`timescale 1ns/100ps

module memory import mycpuPkg::*; (
    input  ctrlT        ctrl,
    input  logic [31:0] aluOut,
    input  logic [31:0] storeData,
    dataBusIf.master    dbus,
    output logic [31:0] result
);

    // Only lw and sw reach the bus
    assign dbus.valid = ctrl.memRead || ctrl.memWrite;
    assign dbus.addr  = aluOut;
    assign dbus.write = ctrl.memWrite;
    assign dbus.wdata = storeData;

    // rdata is sampled in the ready cycle, when the pipe is not frozen
    assign result = ctrl.memToReg ? dbus.rdata : aluOut;

endmodule

//--- verilog/execute.sv
`timescale 1ns/100ps

module execute import mycpuPkg::*; (
    input  stageRegT    bundle,
    input  logic [31:0] vs,
    input  logic [31:0] vt,
    output logic [31:0] aluOut,
    output logic [31:0] storeData
);
    logic [31:0] opB;

    assign opB = bundle.ctrl.aluSrcImm ? bundle.imm : vt;

    always_comb begin
        case (bundle.ctrl.aluOp)
            aluAdd:  aluOut = vs + opB;
            aluSub:  aluOut = vs - opB;
            aluAnd:  aluOut = vs & opB;
            aluOr:   aluOut = vs | opB;
            aluXor:  aluOut = vs ^ opB;
            aluSlt:  aluOut = {31'd0, $signed(vs) < $signed(opB)};
            aluSll:  aluOut = vt << bundle.shamt;
            aluLui:  aluOut = {bundle.imm[15:0], 16'd0};
            default: aluOut = 32'd0;
        endcase
    end

    // sw stores the forwarded rt value
    assign storeData = vt;

endmodule

//--- verilog/decode.sv
`timescale 1ns/100ps

module decode import mycpuPkg::*; (
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] vs,
    input  logic [31:0] vt,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output stageRegT    bundle,
    output logic        branchTaken,
    output logic [31:0] branchTarget
);
    logic [5:0]  op;
    logic [5:0]  funct;
    logic [4:0]  rd;
    logic [15:0] imm16;
    logic [31:0] slotPc;

    assign op     = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];
    assign slotPc = pc + 32'd4;  // Delay slot address

    always_comb begin
        bundle       = '0;
        bundle.vs    = vs;
        bundle.vt    = vt;
        bundle.rs    = rs;
        bundle.rt    = rt;
        bundle.shamt = instr[10:6];
        bundle.dest  = rt;
        bundle.imm   = {{16{imm16[15]}}, imm16};
        bundle.ctrl.aluOp = aluAdd;
        case (op)
            opSpecial: begin
                bundle.dest = rd;
                bundle.ctrl.regWrite = 1'b1;
                case (funct)
                    fnAddu:  bundle.ctrl.aluOp = aluAdd;
                    fnSubu:  bundle.ctrl.aluOp = aluSub;
                    fnAnd:   bundle.ctrl.aluOp = aluAnd;
                    fnOr:    bundle.ctrl.aluOp = aluOr;
                    fnXor:   bundle.ctrl.aluOp = aluXor;
                    fnSlt:   bundle.ctrl.aluOp = aluSlt;
                    fnSll:   bundle.ctrl.aluOp = aluSll;
                    default: bundle.ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                bundle.ctrl.regWrite  = 1'b1;
                bundle.ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                bundle.imm            = {16'd0, imm16};  // Zero extended
                bundle.ctrl.regWrite  = 1'b1;
                bundle.ctrl.aluSrcImm = 1'b1;
                bundle.ctrl.aluOp     = aluOr;
            end
            opLui: begin
                bundle.ctrl.regWrite  = 1'b1;
                bundle.ctrl.aluSrcImm = 1'b1;
                bundle.ctrl.aluOp     = aluLui;
            end
            opLw: begin
                bundle.ctrl.regWrite  = 1'b1;
                bundle.ctrl.memRead   = 1'b1;
                bundle.ctrl.memToReg  = 1'b1;
                bundle.ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                bundle.ctrl.memWrite  = 1'b1;
                bundle.ctrl.aluSrcImm = 1'b1;
            end
            default: ;  // beq, j and unknown opcodes write nothing
        endcase
    end

    assign branchTaken  = (op == opBeq && vs == vt) || op == opJ;
    assign branchTarget = (op == opJ) ? {slotPc[31:28], instr[25:0], 2'b00}
                                      : slotPc + {{14{imm16[15]}}, imm16, 2'b00};

endmodule

//--- verilog/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [31:1];  // No storage for r0

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

//--- verilog/fetch.sv
`timescale 1ns/100ps

module fetch import mycpuPkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        freeze,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    instrBusIf.master   ibus,
    output logic [31:0] pcF,
    output logic [31:0] instrF
);
    logic [31:0] pc;
    logic        held;       // Word already accepted while the pipe was held
    logic [31:0] heldInstr;
    logic        advance;

    assign advance = !freeze && !stall;

    // Request goes out in the first cycle after reset
    assign ibus.valid = !resetn && !held;
    assign ibus.addr  = pc;

    // A nop goes to decode when nothing was fetched
    assign pcF    = pc;
    assign instrF = held ? heldInstr : (ibus.valid ? ibus.data : 32'd0);

    always_ff @(posedge clk) begin
        if (resetn) begin
            pc   <= resetPc;
            held <= 1'b0;
        end else begin
            if (advance) begin
                pc   <= branchTaken ? branchTarget : pc + 32'd4;
                held <= 1'b0;
            end else if (ibus.valid && ibus.ready) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ibus.valid && ibus.ready)
            heldInstr <= ibus.data;
    end

endmodule

//--- verilog/busIf.sv
`timescale 1ns/100ps

interface instrBusIf;
    logic        valid;
    logic [31:0] addr;
    logic [31:0] data;
    logic        ready;  // Data valid in the same cycle

    modport master (output valid, addr, input data, ready);
    modport slave (input valid, addr, output data, ready);
endinterface

interface dataBusIf;
    logic        valid;
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        ready;

    modport master (output valid, addr, write, wdata, input rdata, ready);
    modport slave (input valid, addr, write, wdata, output rdata, ready);
endinterface

//--- verilog/mycpuPkg.sv
package mycpuPkg;

    // Boot vector in kseg1
    localparam logic [31:0] resetPc = 32'hbfc0_0000;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;   // Result comes from load data
        logic  aluSrcImm;  // Operand B is the immediate
        aluOpT aluOp;
    } ctrlT;

    // Decode to execute bundle
    typedef struct packed {
        ctrlT        ctrl;
        logic [31:0] vs;
        logic [31:0] vt;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
    } stageRegT;

endpackage
